//--- robCommit.f
+incdir+hw
hw/robStoragePkg.sv
hw/robPortPkg.sv
hw/robPayloadRam.sv
hw/robPointers.sv
hw/robCompletion.sv
hw/robCommitSelect.sv
hw/robTop.sv
testbench/robTb.sv

//--- Makefile
TOP = robTb
OBJ = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f robCommit.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f robCommit.f \
		--top-module $(TOP) -Mdir $(OBJ) -o V$(TOP)
	./$(OBJ)/V$(TOP) | tee sim.log
	@grep -qx "sim passed" sim.log

clean:
	rm -rf $(OBJ) sim.log

//--- testbench/robTb.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module robTb;
    import robStoragePkg::*;
    import robPortPkg::*;

    localparam int LIMIT = 400;

    logic        clk;
    logic        rst;
    dispatchReqT dispatch;
    wbPortT      writeback;
    robIdxT      allocIdx;
    logic        full;
    commitT      commit;
    excReportT   exception;

    // reference state, indexed by buffer slot
    robEntryT             refMem [`ROB_SIZE];
    excCodeT              refExc [`ROB_SIZE];
    logic [`ROB_SIZE-1:0] wbDone;
    robIdxT               expHead;
    robIdxT               expTail;
    robIdxT               pending [$];
    logic [31:0]          rngState = 32'h7b0c8cfd;
    int                   errCount = 0;
    string                testName = "reset";
    int                   hits [6] = '{default: 0};
    string                hitNames [6] = '{"reset", "alloc", "hold",
                                            "commit", "wrap", "exception"};

    countT   groupSize;
    countT   nCommit;
    countT   refFree;
    robPtrT  slotPtr [`COMMIT_WIDTH];

    robTop u_robTop (
        .clk      (clk),
        .rst      (rst),
        .dispatch (dispatch),
        .writeback(writeback),
        .allocIdx (allocIdx),
        .full     (full),
        .commit   (commit),
        .exception(exception)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic void reportMismatch(string name, logic [31:0] exp, logic [31:0] act);
        errCount++;
        $display("[FAIL] %s %s expected %0h actual %0h", testName, name, exp, act);
    endfunction

    always_comb begin
        groupSize = countT'(dispatch.slot[0].valid) + countT'(dispatch.slot[1].valid);
        nCommit   = countT'(commit.slot[0].valid) + countT'(commit.slot[1].valid);
        refFree   = countT'(`ROB_SIZE) - countT'(expTail - expHead);
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            slotPtr[i] = robPtrT'(commit.headIdx.idx + i);
        end
    end

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            expHead  <= '0;
            expTail  <= '0;
            wbDone   <= '0;
        end else begin
            if (exception.valid) begin
                // buffer is empty after the fault
                expHead  <= robIdxT'(exception.idx + 1'b1);
                expTail  <= robIdxT'(exception.idx + 1'b1);
                wbDone   <= '0;
                hits[5]  <= hits[5] + 1;
            end else begin
                expHead <= robIdxT'(expHead + nCommit);
            end
            if (groupSize != 0 && !full) begin
                for (int i = 0; i < groupSize; i++) begin
                    refMem[robPtrT'(expTail.idx + i)] <= dispatch.slot[i].entry;
                    wbDone[robPtrT'(expTail.idx + i)] <= 1'b0;
                end
                expTail  <= robIdxT'(expTail + groupSize);
                hits[1]  <= hits[1] + 1;
            end
            for (int p = 0; p < `WB_PORTS; p++) begin
                if (writeback.port[p].valid) begin
                    wbDone[writeback.port[p].idx.idx] <= 1'b1;
                    refExc[writeback.port[p].idx.idx] <= writeback.port[p].code;
                end
            end
            if (groupSize != 0 && full) hits[2] <= hits[2] + 1;
            if (nCommit != 0) hits[3] <= hits[3] + 1;
            if (nCommit != 0 && commit.headIdx.dir) hits[4] <= hits[4] + 1;
        end
    end

    aReset: assert property (@(posedge clk) $fell(rst) |-> !full && !commit.slot[0].valid
        && !commit.slot[1].valid && !exception.valid && allocIdx == '0)
        else reportMismatch("reset state", 0, $sampled({full, commit.slot[0].valid,
            commit.slot[1].valid, exception.valid, allocIdx}));
    aAlloc: assert property (@(posedge clk) disable iff (rst)
        (groupSize != 0 && !full) |-> allocIdx == expTail)
        else reportMismatch("alloc index", $sampled(expTail), $sampled(allocIdx));
    aRoom: assert property (@(posedge clk) disable iff (rst)
        (groupSize != 0 && refFree >= groupSize) |-> !full)
        else reportMismatch("full with room", 0, 1);
    aFull: assert property (@(posedge clk) disable iff (rst)
        (groupSize != 0 && full) |-> refFree < groupSize)
        else reportMismatch("free count when full", $sampled(groupSize), $sampled(refFree));
    aHold: assert property (@(posedge clk) disable iff (rst)
        (groupSize != 0 && full) |=> $stable(allocIdx))
        else reportMismatch("held alloc index", $sampled(expTail), $sampled(allocIdx));
    aOrder: assert property (@(posedge clk) disable iff (rst)
        nCommit != 0 |-> commit.headIdx == expHead && commit.slot[0].valid)
        else reportMismatch("commit index", $sampled(expHead), $sampled(commit.headIdx));

    generate
        for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : gSlot
            aEntry: assert property (@(posedge clk) disable iff (rst)
                commit.slot[i].valid |-> commit.slot[i].entry == refMem[slotPtr[i]])
                else reportMismatch("commit entry", $sampled(refMem[slotPtr[i]]),
                    $sampled(commit.slot[i].entry));
            aDone: assert property (@(posedge clk) disable iff (rst)
                commit.slot[i].valid |-> wbDone[slotPtr[i]] && refExc[slotPtr[i]] == EXC_NONE)
                else reportMismatch("commit before writeback", 1, $sampled(wbDone[slotPtr[i]]));
        end
    endgenerate

    aExcIdx: assert property (@(posedge clk) disable iff (rst)
        exception.valid |-> exception.idx == robIdxT'(expHead + nCommit))
        else reportMismatch("exception index", $sampled(robIdxT'(expHead + nCommit)),
            $sampled(exception.idx));
    aExcData: assert property (@(posedge clk) disable iff (rst)
        exception.valid |-> wbDone[exception.idx.idx] && exception.code != EXC_NONE
        && exception.code == refExc[exception.idx.idx]
        && exception.vrd == refMem[exception.idx.idx].vrd)
        else reportMismatch("exception code", $sampled(refExc[exception.idx.idx]),
            $sampled(exception.code));

    task automatic dispatchGroup(input int n);
        int tries;
        @(negedge clk);
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            dispatch.slot[i].valid = (i < n);
            dispatch.slot[i].entry = robEntryT'(nextRand());
        end
        tries = 0;
        #1;
        while (full) begin
            @(negedge clk);
            #1;
            tries++;
            if (tries > LIMIT) begin
                $display("timed out waiting for the buffer to accept a dispatch");
                $display("sim failed");
                $finish;
            end
        end
        for (int i = 0; i < n; i++) begin
            pending.push_back(robIdxT'(allocIdx + i));
        end
        @(negedge clk);
        dispatch = '0;
    endtask

    task automatic offerWhileFull(input int cycles);
        @(negedge clk);
        dispatch.slot[0].valid = 1'b1;
        dispatch.slot[1].valid = 1'b1;
        repeat (cycles) @(negedge clk);
        dispatch = '0;
    endtask

    // random order, two ports per cycle when possible
    task automatic writebackAll();
        int k;
        while (pending.size() > 0) begin
            @(negedge clk);
            writeback = '0;
            for (int p = 0; p < `WB_PORTS && pending.size() > 0; p++) begin
                k = nextRand() % pending.size();
                writeback.port[p].valid = 1'b1;
                writeback.port[p].idx   = pending[k];
                writeback.port[p].code  = EXC_NONE;
                pending.delete(k);
            end
        end
        @(negedge clk);
        writeback = '0;
    endtask

    task automatic drain();
        int tries;
        tries = 0;
        while (expHead != expTail) begin
            @(negedge clk);
            tries++;
            if (tries > LIMIT) begin
                $display("timed out waiting for the buffer to drain");
                $display("sim failed");
                $finish;
            end
        end
    endtask

    task automatic fillRandom(input int total);
        int n;
        n = 0;
        while (n < total) begin
            dispatchGroup((total - n >= 2) ? 1 + int'(nextRand() % 2) : 1);
            n = pending.size();
        end
    endtask

    task automatic faultTest();
        int     k;
        int     tries;
        robIdxT faultIdx;
        fillRandom(5);
        k = nextRand() % pending.size();
        faultIdx = pending[k];
        pending.delete(k);
        writebackAll();
        @(negedge clk);
        writeback.port[0].valid = 1'b1;
        writeback.port[0].idx   = faultIdx;
        writeback.port[0].code  = excCodeT'(nextRand() % 15);
        @(negedge clk);
        writeback = '0;
        tries = 0;
        while (hits[5] == 0) begin
            @(negedge clk);
            tries++;
            if (tries > LIMIT) begin
                $display("timed out waiting for the exception report");
                $display("sim failed");
                $finish;
            end
        end
        pending.delete();
        dispatchGroup(1);
        writebackAll();
        drain();
    endtask

    initial begin
        int missing;
        rst       = 1'b1;
        dispatch  = '0;
        writeback = '0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        hits[0]++;
        $display("test reset done, errors %0d", errCount);

        testName = "fill";
        fillRandom(16);
        offerWhileFull(4);
        $display("test fill done, errors %0d", errCount);

        testName = "commit order";
        writebackAll();
        drain();
        $display("test commit order done, errors %0d", errCount);

        testName = "wrap";
        repeat (5) begin
            fillRandom(7);
            writebackAll();
            drain();
        end
        $display("test wrap done, errors %0d", errCount);

        testName = "exception";
        faultTest();
        $display("test exception done, errors %0d", errCount);

        missing = 0;
        for (int i = 0; i < 6; i++) begin
            if (hits[i] == 0) begin
                $display("check for %s was never reached", hitNames[i]);
                missing++;
            end
        end
        $display("errors %0d, unreached checks %0d", errCount, missing);
        if (errCount == 0 && missing == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- hw/robTop.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module robTop (
    input  logic                    clk,
    input  logic                    rst,
    input  robPortPkg::dispatchReqT dispatch,
    input  robPortPkg::wbPortT      writeback,
    output robStoragePkg::robIdxT   allocIdx,
    output logic                    full,
    output robPortPkg::commitT      commit,
    output robPortPkg::excReportT   exception
);
    import robStoragePkg::*;
    import robPortPkg::*;

    robIdxT                          head;
    robIdxT                          tail;
    countT                           retireCount;
    logic                            flush;
    logic                            accept;
    logic [`COMMIT_WIDTH-1:0]        retireMask;
    logic [`COMMIT_WIDTH-1:0]        doneAtHead;
    excCodeT [`COMMIT_WIDTH-1:0]     excAtHead;
    robEntryT [`COMMIT_WIDTH-1:0]    entriesAtHead;
    allocT                           alloc;
    logic [`DISPATCH_WIDTH-1:0]      ramWe;
    robPtrT [`DISPATCH_WIDTH-1:0]    ramWaddr;
    robEntryT [`DISPATCH_WIDTH-1:0]  ramWdata;
    robPtrT [`COMMIT_WIDTH-1:0]      ramRaddr;

    assign allocIdx = tail;

    always_comb begin
        alloc.tail = tail;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            ramWe[i]    = dispatch.slot[i].valid && !full;
            ramWaddr[i] = robPtrT'(tail.idx + i);
            ramWdata[i] = dispatch.slot[i].entry;
            alloc.en[i] = dispatch.slot[i].valid && accept;
        end
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            ramRaddr[i] = robPtrT'(head.idx + i);
        end
    end

    robPointers u_robPointers (
        .clk        (clk),
        .rst        (rst),
        .dispatch   (dispatch),
        .retireCount(retireCount),
        .flush      (flush),
        .head       (head),
        .tail       (tail),
        .full       (full),
        .accept     (accept)
    );

    robPayloadRam #(
        .DEPTH      (`ROB_SIZE),
        .WIDTH      ($bits(robEntryT)),
        .WRITE_PORTS(`DISPATCH_WIDTH),
        .READ_PORTS (`COMMIT_WIDTH)
    ) u_robPayloadRam (
        .clk  (clk),
        .we   (ramWe),
        .waddr(ramWaddr),
        .wdata(ramWdata),
        .raddr(ramRaddr),
        .rdata(entriesAtHead)
    );

    robCompletion u_robCompletion (
        .clk       (clk),
        .rst       (rst),
        .writeback (writeback),
        .alloc     (alloc),
        .head      (head),
        .retireMask(retireMask),
        .doneAtHead(doneAtHead),
        .excAtHead (excAtHead)
    );

    robCommitSelect u_robCommitSelect (
        .clk          (clk),
        .rst          (rst),
        .head         (head),
        .tail         (tail),
        .doneAtHead   (doneAtHead),
        .excAtHead    (excAtHead),
        .entriesAtHead(entriesAtHead),
        .retireMask   (retireMask),
        .retireCount  (retireCount),
        .flush        (flush),
        .commit       (commit),
        .exception    (exception)
    );

endmodule

//--- hw/robCommitSelect.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module robCommitSelect (
    input  logic                                       clk,
    input  logic                                       rst,
    input  robStoragePkg::robIdxT                      head,
    input  robStoragePkg::robIdxT                      tail,
    input  logic [`COMMIT_WIDTH-1:0]                   doneAtHead,
    input  robStoragePkg::excCodeT [`COMMIT_WIDTH-1:0]  excAtHead,
    input  robStoragePkg::robEntryT [`COMMIT_WIDTH-1:0] entriesAtHead,
    output logic [`COMMIT_WIDTH-1:0]                   retireMask,
    output robStoragePkg::countT                       retireCount,
    output logic                                       flush,
    output robPortPkg::commitT                         commit,
    output robPortPkg::excReportT                      exception
);
    import robStoragePkg::*;

    localparam int SLOT_W = (`COMMIT_WIDTH > 1) ? $clog2(`COMMIT_WIDTH) : 1;

    countT                    validCount;
    logic [`COMMIT_WIDTH-1:0] commitMask;
    logic [SLOT_W-1:0]        excSlot;
    logic                     inGroup;

    // occupancy from the dir-extended pointers
    assign validCount = countT'(tail - head);

    always_comb begin
        inGroup     = 1'b1;
        retireMask  = '0;
        commitMask  = '0;
        retireCount = '0;
        flush       = 1'b0;
        excSlot     = '0;
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            if (inGroup && validCount > countT'(i) && doneAtHead[i]) begin
                retireMask[i] = 1'b1;
                retireCount   = retireCount + 1'b1;
                if (excAtHead[i] != EXC_NONE) begin
                    // faulting entry leaves the buffer but is not committed
                    flush   = 1'b1;
                    excSlot = SLOT_W'(i);
                    inGroup = 1'b0;
                end else begin
                    commitMask[i] = 1'b1;
                end
            end else begin
                inGroup = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            commit    <= '0;
            exception <= '0;
        end else begin
            commit.headIdx <= head;
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                commit.slot[i].valid <= commitMask[i];
                commit.slot[i].entry <= entriesAtHead[i];
            end
            exception.valid <= flush;
            exception.idx   <= robIdxT'(head + countT'(excSlot));
            exception.code  <= excAtHead[excSlot];
            exception.vrd   <= entriesAtHead[excSlot].vrd;
        end
    end

    generate
        for (genvar i = 0; i < `COMMIT_WIDTH; i++) begin : gSameIdx
            assert property (@(posedge clk) disable iff (rst)
                !(commit.slot[i].valid && exception.valid
                  && exception.idx == robIdxT'(commit.headIdx + i)))
                else $error("robCommitSelect: slot %0d commits the faulting entry", i);
        end
    endgenerate

endmodule

//--- hw/robCompletion.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module robCompletion (
    input  logic                                      clk,
    input  logic                                      rst,
    input  robPortPkg::wbPortT                        writeback,
    input  robPortPkg::allocT                         alloc,
    input  robStoragePkg::robIdxT                     head,
    input  logic [`COMMIT_WIDTH-1:0]                  retireMask,
    output logic [`COMMIT_WIDTH-1:0]                  doneAtHead,
    output robStoragePkg::excCodeT [`COMMIT_WIDTH-1:0] excAtHead
);
    import robStoragePkg::*;

    logic [`ROB_SIZE-1:0] done;
    excCodeT              excCode [`ROB_SIZE];

    // later loops take priority on the same entry
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= '0;
        end else begin
            for (int i = 0; i < `COMMIT_WIDTH; i++) begin
                if (retireMask[i]) begin
                    done[robPtrT'(head.idx + i)] <= 1'b0;
                end
            end
            for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
                if (alloc.en[i]) begin
                    done[robPtrT'(alloc.tail.idx + i)] <= 1'b0;
                end
            end
            for (int i = 0; i < `WB_PORTS; i++) begin
                if (writeback.port[i].valid) begin
                    done[writeback.port[i].idx.idx] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < `WB_PORTS; i++) begin
            if (writeback.port[i].valid) begin
                excCode[writeback.port[i].idx.idx] <= writeback.port[i].code;
            end
        end
    end

    // status of the oldest entries
    always_comb begin
        for (int i = 0; i < `COMMIT_WIDTH; i++) begin
            doneAtHead[i] = done[robPtrT'(head.idx + i)];
            excAtHead[i]  = excCode[robPtrT'(head.idx + i)];
        end
    end

    generate
        for (genvar i = 0; i < `WB_PORTS; i++) begin : gWbCheck
            assert property (@(posedge clk) disable iff (rst)
                writeback.port[i].valid |-> !done[writeback.port[i].idx.idx])
                else $error("robCompletion: port %0d writes back a completed entry", i);
        end
    endgenerate

endmodule

//--- hw/robPointers.sv
`timescale 1ns/1ps
`include "rob_defs.svh"

module robPointers (
    input  logic                    clk,
    input  logic                    rst,
    input  robPortPkg::dispatchReqT dispatch,
    input  robStoragePkg::countT    retireCount,
    input  logic                    flush,
    output robStoragePkg::robIdxT   head,
    output robStoragePkg::robIdxT   tail,
    output logic                    full,
    output logic                    accept
);
    import robStoragePkg::*;

    countT  freeCount;
    countT  validCount;
    countT  groupSize;
    countT  addNum;
    robIdxT headNext;

    always_comb begin
        groupSize = '0;
        for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
            groupSize = groupSize + countT'(dispatch.slot[i].valid);
        end
    end

    assign full   = flush || (freeCount < groupSize);
    assign accept = !full && (groupSize != '0);
    assign addNum = accept ? groupSize : '0;

    // dir is the top bit so the add carries into it on wrap
    assign headNext = robIdxT'(head + retireCount);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head       <= '0;
            tail       <= '0;
            freeCount  <= countT'(`ROB_SIZE);
            validCount <= '0;
        end else begin
            head <= headNext;
            if (flush) begin
                // everything younger than the fault is dropped
                tail       <= headNext;
                freeCount  <= countT'(`ROB_SIZE);
                validCount <= '0;
            end else begin
                tail       <= robIdxT'(tail + addNum);
                freeCount  <= freeCount + retireCount - addNum;
                validCount <= validCount - retireCount + addNum;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) validCount <= countT'(`ROB_SIZE))
        else $error("robPointers: valid count %0d above buffer size", validCount);

    assert property (@(posedge clk) disable iff (rst) retireCount <= validCount)
        else $error("robPointers: retiring %0d entries with only %0d valid", retireCount,
            validCount);

endmodule

//--- hw/robPayloadRam.sv
`timescale 1ns/1ps

module robPayloadRam #(
    parameter int DEPTH       = 16,
    parameter int WIDTH       = 18,
    parameter int WRITE_PORTS = 2,
    parameter int READ_PORTS  = 2
) (
    input  logic                                     clk,
    input  logic [WRITE_PORTS-1:0]                   we,
    input  logic [WRITE_PORTS-1:0][$clog2(DEPTH)-1:0] waddr,
    input  logic [WRITE_PORTS-1:0][WIDTH-1:0]        wdata,
    input  logic [READ_PORTS-1:0][$clog2(DEPTH)-1:0]  raddr,
    output logic [READ_PORTS-1:0][WIDTH-1:0]         rdata
);

    logic [WIDTH-1:0] mem [DEPTH];

    // higher port is written last and wins a clash
    always_ff @(posedge clk) begin
        for (int i = 0; i < WRITE_PORTS; i++) begin
            if (we[i]) begin
                mem[waddr[i]] <= wdata[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < READ_PORTS; i++) begin
            rdata[i] = mem[raddr[i]];
        end
    end

    generate
        for (genvar i = 0; i < WRITE_PORTS; i++) begin : gPortA
            for (genvar j = i + 1; j < WRITE_PORTS; j++) begin : gPortB
                assert property (@(posedge clk)
                    !(we[i] && we[j] && waddr[i] == waddr[j]))
                    else $error("robPayloadRam: write ports %0d and %0d share an address", i, j);
            end
        end
    endgenerate

endmodule

//--- hw/robPortPkg.sv
`include "rob_defs.svh"

package robPortPkg;

    typedef struct packed {
        logic                    valid;
        robStoragePkg::robEntryT entry;
    } dispatchSlotT;

    // valid slots are packed from slot 0
    typedef struct packed {
        dispatchSlotT [`DISPATCH_WIDTH-1:0] slot;
    } dispatchReqT;

    typedef struct packed {
        logic                   valid;
        robStoragePkg::robIdxT  idx;
        robStoragePkg::excCodeT code;
    } wbSlotT;

    typedef struct packed {
        wbSlotT [`WB_PORTS-1:0] port;
    } wbPortT;

    typedef struct packed {
        logic                    valid;
        robStoragePkg::robEntryT entry;
    } commitSlotT;

    // slot i holds the entry at headIdx + i
    typedef struct packed {
        commitSlotT [`COMMIT_WIDTH-1:0] slot;
        robStoragePkg::robIdxT          headIdx;
    } commitT;

    typedef struct packed {
        logic                   valid;
        robStoragePkg::robIdxT  idx;
        robStoragePkg::excCodeT code;
        logic [`VREG_WIDTH-1:0] vrd;
    } excReportT;

    // entries claimed by an accepted dispatch group
    typedef struct packed {
        robStoragePkg::robIdxT      tail;
        logic [`DISPATCH_WIDTH-1:0] en;
    } allocT;

endpackage

//--- hw/robStoragePkg.sv
`include "rob_defs.svh"

package robStoragePkg;

    // slot number within the buffer
    typedef logic [`ROB_WIDTH-1:0] robPtrT;

    // dir toggles each time the pointer passes the last entry
    typedef struct packed {
        logic   dir;
        robPtrT idx;
    } robIdxT;

    typedef logic [`EXC_WIDTH-1:0] excCodeT;

    // all ones means no exception
    localparam excCodeT EXC_NONE = '1;

    // holds 0 up to ROB_SIZE
    typedef logic [`ROB_WIDTH:0] countT;

    typedef struct packed {
        logic                   we;
        logic [`VREG_WIDTH-1:0] vrd;
        logic [`PREG_WIDTH-1:0] prd;
        logic [`PREG_WIDTH-1:0] oldPrd;
    } robEntryT;

endpackage

//--- hw/rob_defs.svh
`ifndef ROB_DEFS_SVH
`define ROB_DEFS_SVH

// buffer geometry
`define ROB_SIZE       16
`define ROB_WIDTH      4

// per-cycle bandwidth
`define DISPATCH_WIDTH 2
`define COMMIT_WIDTH   2
`define WB_PORTS       2

// field widths
`define EXC_WIDTH      4
`define PREG_WIDTH     6
`define VREG_WIDTH     5

`endif
